// File: include/rtc_defines.svh
`ifndef RTC_DEFINES_SVH
`define RTC_DEFINES_SVH

////////////////////////////////////////
// sweep layout

// fields read per sweep, fits a 4-bit index
`define RTC_NUM_FIELDS 9

// transfer command, latches the chip counters
`define RTC_CMD_ADDR 8'hF0

// clock fields at base+1..base+6, timer fields at base+1..base+3
`define RTC_CLOCK_BASE 8'h20
`define RTC_TIMER_BASE 8'h40

////////////////////////////////////////
// bus phase lengths in clocks

`define RTC_ADDR_CYCLES 2
`define RTC_RD_CYCLES   3

`endif

// File: src/rtc_pkg.sv
package rtc_pkg;

  ////////////////////////////////////////
  // byte as seen on the bus

  // the chip returns packed BCD, so the same byte
  // is used raw on the bus and split into digits
  typedef union packed {
    logic [7:0] raw;       // bus byte
    struct packed {
      logic [3:0] tens;    // upper digit
      logic [3:0] ones;    // lower digit
    } bcd;
  } rtc_byte_t;

  ////////////////////////////////////////
  // sequencer steps

  typedef enum logic [3:0] {
    step_idle    = 4'd0,   // waiting for run
    step_command = 4'd1,   // transfer command cycle
    step_field   = 4'd2,   // one of the field reads
    step_final   = 4'd3    // sweep end marker
  } seq_step_t;

endpackage

// File: src/rtc_read_sequencer.sv
`timescale 1ns/1ps
`include "rtc_defines.svh"

module rtc_read_sequencer (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               run,
  input  logic               cycle_done,
  output logic               cycle_start,
  output logic [7:0]         cycle_addr,
  output logic [3:0]         capture_idx,
  output logic               cycle_is_read,
  output logic               sweep_done,
  output rtc_pkg::seq_step_t step
);

  // first six fields live in the clock block
  localparam int clock_fields = 6;

  logic [3:0] field_idx;   // field currently being read
  logic       issued;      // start already sent in this step
  logic       last_field;
  logic [7:0] field_addr;

  ////////////////////////////////////////
  // address of the current field

  assign last_field = (field_idx == 4'(`RTC_NUM_FIELDS - 1));

  always_comb begin
    if (field_idx < 4'(clock_fields)) begin
      field_addr = `RTC_CLOCK_BASE + 8'(field_idx) + 8'd1;   // 21..26
    end else begin
      // timer block restarts at base+1
      field_addr = `RTC_TIMER_BASE + 8'(field_idx) - 8'(clock_fields) + 8'd1;
    end
  end

  assign cycle_addr    = (step == rtc_pkg::step_command) ? `RTC_CMD_ADDR : field_addr;
  assign cycle_is_read = (step == rtc_pkg::step_field);
  assign capture_idx   = field_idx;   // still valid on the done clock
  assign sweep_done    = (step == rtc_pkg::step_final);

  ////////////////////////////////////////
  // step FSM

  always_ff @(posedge clk) begin
    if (!rst_n || !run) begin
      // dropping run abandons the sweep, next one starts with the command
      step        <= rtc_pkg::step_idle;
      field_idx   <= '0;
      issued      <= 1'b0;
      cycle_start <= 1'b0;
    end else begin
      cycle_start <= 1'b0;   // pulse only

      case (step)
        rtc_pkg::step_idle: begin
          step      <= rtc_pkg::step_command;
          field_idx <= '0;
          issued    <= 1'b0;
        end

        rtc_pkg::step_command,
        rtc_pkg::step_field: begin
          if (!issued) begin
            // one bus cycle per step, issued one clock after entry
            cycle_start <= 1'b1;
            issued      <= 1'b1;
          end else if (cycle_done) begin
            issued <= 1'b0;
            if (step == rtc_pkg::step_command) begin
              step      <= rtc_pkg::step_field;
              field_idx <= '0;
            end else if (last_field) begin
              step <= rtc_pkg::step_final;   // idx held at last field
            end else begin
              field_idx <= field_idx + 4'd1;
            end
          end
        end

        rtc_pkg::step_final: begin
          // sweep_done is high for this one clock, then loop
          step      <= rtc_pkg::step_command;
          field_idx <= '0;
          issued    <= 1'b0;
        end

        default: begin
          step   <= rtc_pkg::step_idle;
          issued <= 1'b0;
        end
      endcase
    end
  end

endmodule

// File: src/rtc_bus_cycle.sv
`timescale 1ns/1ps
`include "rtc_defines.svh"

module rtc_bus_cycle (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               run,
  input  logic               cycle_start,
  input  logic [7:0]         cycle_addr,
  input  logic               cycle_is_read,
  input  logic [7:0]         ad_in,
  output logic [7:0]         ad_out,
  output logic               ad_oe,
  output logic               as,
  output logic               rd_n,
  output logic               cycle_done,
  output logic               capture,
  output rtc_pkg::rtc_byte_t capture_data
);

  localparam logic [1:0] ph_idle = 2'd0;
  localparam logic [1:0] ph_addr = 2'd1;
  localparam logic [1:0] ph_read = 2'd2;

  logic [1:0] phase;
  logic [2:0] cnt;        // clocks spent in the current phase
  logic       is_read;    // cycle type taken at start
  logic       addr_last;
  logic       rd_last;

  assign addr_last = (cnt == 3'(`RTC_ADDR_CYCLES - 1));
  assign rd_last   = (cnt == 3'(`RTC_RD_CYCLES - 1));

  ////////////////////////////////////////
  // phase control and strobes

  always_ff @(posedge clk) begin
    if (!rst_n || !run) begin
      phase      <= ph_idle;
      cnt        <= '0;
      as         <= 1'b0;
      ad_oe      <= 1'b0;
      rd_n       <= 1'b1;
      cycle_done <= 1'b0;
      capture    <= 1'b0;
    end else begin
      cycle_done <= 1'b0;
      capture    <= 1'b0;

      case (phase)
        ph_idle: begin
          if (cycle_start) begin
            phase <= ph_addr;
            cnt   <= '0;
            as    <= 1'b1;   // address goes out with the strobe
            ad_oe <= 1'b1;
          end
        end

        ph_addr: begin
          if (addr_last) begin
            phase <= ph_read;
            cnt   <= '0;
            as    <= 1'b0;
            ad_oe <= 1'b0;   // release bus before the chip drives it
            rd_n  <= 1'b0;
          end else begin
            cnt <= cnt + 3'd1;
          end
        end

        ph_read: begin
          if (rd_last) begin
            phase      <= ph_idle;
            cnt        <= '0;
            rd_n       <= 1'b1;
            cycle_done <= 1'b1;
            capture    <= is_read;   // command cycle reads but keeps nothing
          end else begin
            cnt <= cnt + 3'd1;
          end
        end

        default: phase <= ph_idle;
      endcase
    end
  end

  ////////////////////////////////////////
  // address and data path

  always_ff @(posedge clk) begin
    if (phase == ph_idle && cycle_start) begin
      ad_out  <= cycle_addr;
      is_read <= cycle_is_read;
    end
    if (phase == ph_read && rd_last) begin
      capture_data.raw <= ad_in;   // sampled on last read clock
    end
  end

endmodule

// File: src/rtc_field_reg.sv
`timescale 1ns/1ps

module rtc_field_reg #(
  parameter int FIELD_IDX = 0
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               capture,
  input  logic [3:0]         capture_idx,
  input  rtc_pkg::rtc_byte_t capture_data,
  output rtc_pkg::rtc_byte_t value,
  output logic               bcd_ok
);

  logic hit;         // capture addressed to this field
  logic digits_ok;

  assign hit = capture && (capture_idx == 4'(FIELD_IDX));

  // each digit of a packed BCD byte must be 0..9
  assign digits_ok = (capture_data.bcd.tens <= 4'd9) &&
                     (capture_data.bcd.ones <= 4'd9);

  ////////////////////////////////////////
  // holding register

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      value  <= '0;
      bcd_ok <= 1'b0;   // nothing read yet
    end else if (hit) begin
      value  <= capture_data;
      bcd_ok <= digits_ok;
    end
  end

endmodule

// File: src/rtc_field_snapshot.sv
`timescale 1ns/1ps
`include "rtc_defines.svh"

module rtc_field_snapshot (
  input  logic                               clk,
  input  logic                               rst_n,
  input  logic                               sweep_done,
  input  logic [3:0]                         field_sel,
  input  logic [`RTC_NUM_FIELDS-1:0][7:0]    live_values,
  input  logic [`RTC_NUM_FIELDS-1:0]         live_ok,
  output logic [7:0]                         field_value,
  output logic [3:0]                         field_tens,
  output logic [3:0]                         field_ones,
  output logic                               field_bcd_ok
);

  logic [`RTC_NUM_FIELDS-1:0][7:0] snap_val;   // copy from the last sweep end
  logic [`RTC_NUM_FIELDS-1:0]      snap_ok;
  rtc_pkg::rtc_byte_t              pick_byte;
  logic                            pick_ok;
  rtc_pkg::rtc_byte_t              out_byte;

  // live values pass straight through on the copy clock
  always_comb begin
    pick_byte = '0;
    pick_ok   = 1'b0;
    if (field_sel < 4'(`RTC_NUM_FIELDS)) begin
      pick_byte.raw = sweep_done ? live_values[field_sel] : snap_val[field_sel];
      pick_ok       = sweep_done ? live_ok[field_sel] : snap_ok[field_sel];
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      snap_val     <= '0;
      snap_ok      <= '0;
      out_byte     <= '0;
      field_bcd_ok <= 1'b0;
    end else begin
      if (sweep_done) begin
        snap_val <= live_values;   // all fields from one sweep
        snap_ok  <= live_ok;
      end
      out_byte     <= pick_byte;
      field_bcd_ok <= pick_ok;
    end
  end

  assign field_value = out_byte.raw;
  assign field_tens  = out_byte.bcd.tens;
  assign field_ones  = out_byte.bcd.ones;

endmodule

// File: src/rtc_reader_top.sv
`timescale 1ns/1ps
`include "rtc_defines.svh"

module rtc_reader_top (
  input  logic       clk,
  input  logic       rst_n,
  input  logic       run,
  input  logic [3:0] field_sel,
  input  logic [7:0] ad_in,
  output logic [7:0] ad_out,
  output logic       ad_oe,
  output logic       as,
  output logic       rd_n,
  output logic [7:0] field_value,
  output logic [3:0] field_tens,
  output logic [3:0] field_ones,
  output logic       field_bcd_ok,
  output logic       sweep_done
);

  logic                            cycle_start;
  logic [7:0]                      cycle_addr;
  logic                            cycle_is_read;
  logic                            cycle_done;
  logic                            capture;
  rtc_pkg::rtc_byte_t              capture_data;
  logic [3:0]                      capture_idx;
  rtc_pkg::seq_step_t              step;          // observed by the bound checker
  logic [`RTC_NUM_FIELDS-1:0][7:0] live_values;
  logic [`RTC_NUM_FIELDS-1:0]      live_ok;

  ////////////////////////////////////////
  // control and bus

  rtc_read_sequencer i_read_sequencer (
    .clk           (clk),
    .rst_n         (rst_n),
    .run           (run),
    .cycle_done    (cycle_done),
    .cycle_start   (cycle_start),
    .cycle_addr    (cycle_addr),
    .capture_idx   (capture_idx),
    .cycle_is_read (cycle_is_read),
    .sweep_done    (sweep_done),
    .step          (step)
  );

  rtc_bus_cycle i_bus_cycle (
    .clk           (clk),
    .rst_n         (rst_n),
    .run           (run),
    .cycle_start   (cycle_start),
    .cycle_addr    (cycle_addr),
    .cycle_is_read (cycle_is_read),
    .ad_in         (ad_in),
    .ad_out        (ad_out),
    .ad_oe         (ad_oe),
    .as            (as),
    .rd_n          (rd_n),
    .cycle_done    (cycle_done),
    .capture       (capture),
    .capture_data  (capture_data)
  );

  ////////////////////////////////////////
  // field storage and read-out

  for (genvar k = 0; k < `RTC_NUM_FIELDS; k++) begin : g_field
    rtc_field_reg #(
      .FIELD_IDX (k)
    ) i_field_reg (
      .clk          (clk),
      .rst_n        (rst_n),
      .capture      (capture),
      .capture_idx  (capture_idx),
      .capture_data (capture_data),
      .value        (live_values[k]),
      .bcd_ok       (live_ok[k])
    );
  end

  rtc_field_snapshot i_field_snapshot (
    .clk          (clk),
    .rst_n        (rst_n),
    .sweep_done   (sweep_done),
    .field_sel    (field_sel),
    .live_values  (live_values),
    .live_ok      (live_ok),
    .field_value  (field_value),
    .field_tens   (field_tens),
    .field_ones   (field_ones),
    .field_bcd_ok (field_bcd_ok)
  );

endmodule

// File: sim/rtc_reader_properties.sv
`timescale 1ns/1ps
`include "rtc_defines.svh"

module rtc_reader_properties (
  input logic               clk,
  input logic               rst_n,
  input logic               run,
  input logic [7:0]         ad_out,
  input logic [7:0]         ad_in,
  input logic               ad_oe,
  input logic               as,
  input logic               rd_n,
  input logic               sweep_done,
  input rtc_pkg::seq_step_t step,
  input logic [3:0]         field_sel,
  input logic [7:0]         field_value,
  input logic [3:0]         field_tens,
  input logic [3:0]         field_ones,
  input logic               field_bcd_ok
);

  localparam int cycles_per_sweep = `RTC_NUM_FIELDS + 1;   // command plus fields

  int unsigned err_cnt = 0;   // failed assertions so far

  logic [3:0]                      cyc_n;      // bus cycles started in this sweep
  logic                            as_q;
  logic [3:0]                      sel_q;
  logic                            have_snap;  // a full sweep ended since reset
  logic [`RTC_NUM_FIELDS-1:0][7:0] seen;       // bytes read in the running sweep
  logic [`RTC_NUM_FIELDS-1:0][7:0] snap;
  logic [7:0]                      exp_byte;   // byte the selected field should show
  logic                            exp_ok;

  // bus cycle n of a sweep, command first
  function automatic logic [7:0] sweep_addr(input logic [3:0] n);
    if (n == 4'd0) return `RTC_CMD_ADDR;
    if (n <= 4'd6) return `RTC_CLOCK_BASE + 8'(n);
    return `RTC_TIMER_BASE + 8'(n) - 8'd6;
  endfunction

  function automatic logic [7:0] snap_byte(input logic [3:0] sel);
    if (sel < 4'(`RTC_NUM_FIELDS)) return snap[sel];
    return 8'h00;
  endfunction

  assign exp_byte = snap_byte(sel_q);
  // valid only for a real field with both digits 0..9
  assign exp_ok   = (sel_q < 4'(`RTC_NUM_FIELDS)) &&
                    (exp_byte[7:4] <= 4'd9) && (exp_byte[3:0] <= 4'd9);

  ////////////////////////////////////////
  // reference of what the chip returned

  always_ff @(posedge clk) begin
    sel_q <= field_sel;
    if (!rst_n) begin
      cyc_n     <= '0;
      as_q      <= 1'b0;
      have_snap <= 1'b0;
      seen      <= '0;
      snap      <= '0;
    end else begin
      as_q <= as;
      if (!run || sweep_done) begin
        cyc_n <= '0;   // next sweep starts with the command
      end else if (as && !as_q) begin
        cyc_n <= cyc_n + 4'd1;
      end
      if (!rd_n && cyc_n >= 4'd2 && cyc_n <= 4'(cycles_per_sweep)) begin
        seen[cyc_n - 4'd2] <= ad_in;   // field k is bus cycle k+1
      end
      if (sweep_done) begin
        snap      <= seen;
        have_snap <= 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // bus timing

  a_idle: assert property (@(posedge clk)
    (!rst_n || !run) |=> (!as && !ad_oe && rd_n && !sweep_done))
    else begin err_cnt++; $error("bus strobes active during reset or with run low"); end

  a_step_reset: assert property (@(posedge clk) !rst_n |=> step == rtc_pkg::step_idle)
    else begin err_cnt++; $error("sequencer not idle after reset"); end

  a_oe_with_as: assert property (@(posedge clk) disable iff (!rst_n)
    (ad_oe == as) && !(as && !rd_n))
    else begin err_cnt++; $error("bus driven outside the address phase"); end

  a_bus_shape: assert property (@(posedge clk) disable iff (!rst_n || !run)
    $rose(as) |-> ad_oe ##1 (as && ad_oe) ##1 (!as && !ad_oe && !rd_n)
      ##1 (!ad_oe && !rd_n) ##1 (!ad_oe && !rd_n) ##1 (rd_n && !as))
    else begin err_cnt++; $error("address or read phase has the wrong length"); end

  ////////////////////////////////////////
  // sweep order and snapshot

  a_addr_order: assert property (@(posedge clk) disable iff (!rst_n || !run)
    $rose(as) |-> (cyc_n < 4'(cycles_per_sweep)) && (ad_out == sweep_addr(cyc_n)))
    else begin
      err_cnt++;
      $error("Error addr_order: expected %h, actual %h", sweep_addr(cyc_n), ad_out);
    end

  a_sweep_end: assert property (@(posedge clk) disable iff (!rst_n)
    sweep_done |-> (cyc_n == 4'(cycles_per_sweep)) ##1 !sweep_done)
    else begin
      err_cnt++;
      $error("Error sweep_end: expected %0d cycles, actual %0d", cycles_per_sweep, cyc_n);
    end

  a_snap_value: assert property (@(posedge clk) disable iff (!rst_n)
    have_snap |-> field_value == exp_byte)
    else begin
      err_cnt++;
      $error("Error snap_value: expected %h, actual %h", exp_byte, field_value);
    end

  a_digits: assert property (@(posedge clk) disable iff (!rst_n)
    have_snap |-> (field_tens == exp_byte[7:4]) && (field_ones == exp_byte[3:0]))
    else begin
      err_cnt++;
      $error("Error digits: expected %h, actual %h", exp_byte, {field_tens, field_ones});
    end

  a_bcd_ok: assert property (@(posedge clk) disable iff (!rst_n)
    have_snap |-> field_bcd_ok == exp_ok)
    else begin
      err_cnt++;
      $error("Error bcd_ok: expected %b, actual %b", exp_ok, field_bcd_ok);
    end

endmodule

bind rtc_reader_top rtc_reader_properties i_reader_properties (
  .clk          (clk),
  .rst_n        (rst_n),
  .run          (run),
  .ad_out       (ad_out),
  .ad_in        (ad_in),
  .ad_oe        (ad_oe),
  .as           (as),
  .rd_n         (rd_n),
  .sweep_done   (sweep_done),
  .step         (step),
  .field_sel    (field_sel),
  .field_value  (field_value),
  .field_tens   (field_tens),
  .field_ones   (field_ones),
  .field_bcd_ok (field_bcd_ok)
);

// File: sim/rtc_reader_tb.sv
`timescale 1ns/1ps
`include "rtc_defines.svh"

module rtc_reader_tb;

  localparam int clk_period   = 4;
  // per bus cycle: start, address, read, done and step change
  localparam int sweep_clocks =
    (`RTC_NUM_FIELDS + 1) * (`RTC_ADDR_CYCLES + `RTC_RD_CYCLES + 3) + 2;
  localparam int watchdog_ns  = 4 * sweep_clocks * 2 * clk_period;

  logic        clk;
  logic        rst_n;
  logic        run;
  logic [3:0]  field_sel;
  logic [7:0]  ad_in;
  logic [7:0]  ad_out;
  logic        ad_oe;
  logic        as;
  logic        rd_n;
  logic [7:0]  field_value;
  logic [3:0]  field_tens;
  logic [3:0]  field_ones;
  logic        field_bcd_ok;
  logic        sweep_done;

  logic [7:0]  chip_mem [0:255];
  logic [7:0]  chip_addr;    // latched during the address phase
  logic [15:0] lfsr_state;

  rtc_reader_top i_rtc_reader_top (
    .clk          (clk),
    .rst_n        (rst_n),
    .run          (run),
    .field_sel    (field_sel),
    .ad_in        (ad_in),
    .ad_out       (ad_out),
    .ad_oe        (ad_oe),
    .as           (as),
    .rd_n         (rd_n),
    .field_value  (field_value),
    .field_tens   (field_tens),
    .field_ones   (field_ones),
    .field_bcd_ok (field_bcd_ok),
    .sweep_done   (sweep_done)
  );

  initial begin
    clk = 1'b0;
    forever #(clk_period / 2) clk = ~clk;
  end

  ////////////////////////////////////////
  // chip model

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
  endfunction

  task automatic next_random_byte(output logic [7:0] b);
    for (int i = 0; i < 8; i++) begin
      lfsr_state = lfsr_next(lfsr_state);   // one step per bit
      b = {b[6:0], lfsr_state[0]};
    end
  endtask

  task automatic fill_chip_memory();
    logic [7:0] b;
    for (int a = 0; a < 256; a++) begin
      next_random_byte(b);
      if (a % 4 == 0) begin
        b = {4'(b[7:4] % 4'd10), 4'(b[3:0] % 4'd10)};   // valid BCD
      end
      chip_mem[a] = b;
    end
  endtask

  always @(posedge clk) begin
    #1;
    if (as) chip_addr = ad_out;
    ad_in = rd_n ? 8'h00 : chip_mem[chip_addr];
  end

  ////////////////////////////////////////
  // stimulus

  task automatic wait_sweep_end();
    do @(posedge clk); while (!sweep_done);
  endtask

  task automatic walk_field_sel();
    for (int k = 0; k <= 10; k++) begin
      @(posedge clk);
      #1 field_sel = 4'(k);
    end
    @(posedge clk);
  endtask

  always @(posedge clk) begin
    if (i_rtc_reader_top.i_reader_properties.err_cnt != 0) begin
      $display("Something failed");
      $fatal(1, "a bound assertion reported a failure");
    end
  end

  initial begin
    #(watchdog_ns);
    $display("Something failed");
    $fatal(1, "watchdog expired before the sweeps completed");
  end

  initial begin
    rst_n      = 1'b0;
    run        = 1'b0;
    field_sel  = 4'd0;
    ad_in      = 8'h00;
    chip_addr  = 8'h00;
    lfsr_state = 16'd54225;
    fill_chip_memory();
    repeat (5) @(posedge clk);
    #1 rst_n = 1'b1;
    repeat (4) @(posedge clk);   // idle with run low
    #1 run = 1'b1;
    repeat (2) begin
      wait_sweep_end();
      walk_field_sel();
    end
    // abandon the running sweep a few bus cycles in
    repeat (4) @(posedge as);
    @(posedge clk);
    #1 run = 1'b0;
    fill_chip_memory();
    repeat (6) @(posedge clk);
    #1 run = 1'b1;
    wait_sweep_end();
    walk_field_sel();
    repeat (2) @(posedge clk);
    #1;   // let assertions of the last edge settle
    if (i_rtc_reader_top.i_reader_properties.err_cnt != 0) begin
      $display("Something failed");
      $fatal(1, "a bound assertion reported a failure");
    end else begin
      $display("Everything OK");
      $finish;
    end
  end

endmodule

// File: flist.f
+incdir+include
src/rtc_pkg.sv
src/rtc_read_sequencer.sv
src/rtc_bus_cycle.sv
src/rtc_field_reg.sv
src/rtc_field_snapshot.sv
src/rtc_reader_top.sv
sim/rtc_reader_properties.sv
sim/rtc_reader_tb.sv

// File: run.sh
#!/bin/sh
# build and run the testbench with Verilator, verdict taken from the log
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module rtc_reader_tb -f flist.f

# keep going after an assertion so the testbench can report it
./obj_dir/Vrtc_reader_tb +verilator+error+limit+100 > sim.log 2>&1 || true
cat sim.log

if grep -q "Something failed" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "Everything OK" sim.log; then
  echo "simulation ended without a verdict"
  exit 1
fi
